/* hdl/clos_pkg.sv */
// shared types for the clos fabric scheduler; imported by the allocators and the top level
package clos_pkg;

   // router ports of the mesh: south, west, north, east, local
   localparam int NUM_DIRS = 5;

   // port direction, the value doubles as the port index
   typedef enum logic [2:0] {
      DIR_S = 3'd0,
      DIR_W = 3'd1,
      DIR_N = 3'd2,
      DIR_E = 3'd3,
      DIR_L = 3'd4
   } dir_t;

   // channel request, also used for a request on an im to cm link
   typedef struct packed {
      logic valid;
      dir_t dst;
   } vc_req_t;

   // setting of one output of a central module
   // src is the input port that drives this output in the slot
   typedef struct packed {
      logic valid;
      dir_t src;
   } cm_out_cfg_t;

endpackage

/* hdl/rr_arbiter.sv */
// round-robin arbiter with a rotating priority pointer, instantiated by the im and cm allocators
module rr_arbiter #(
   parameter int WIDTH = 4
) (
   input  logic             clk,
   input  logic             arst_n,
   input  logic [WIDTH-1:0] req,
   input  logic             advance,
   output logic [WIDTH-1:0] gnt
);

   // pointer needs at least one bit, even for a single requester
   localparam int PTR_W = (WIDTH > 1) ? $clog2(WIDTH) : 1;

   logic [PTR_W-1:0] ptr_q;
   logic [PTR_W-1:0] win_idx;

   // scan starting at the pointer, first requester wins
   always_comb begin
      int   idx;
      logic found;
      gnt     = '0;
      win_idx = '0;
      found   = 1'b0;
      for (int i = 0; i < WIDTH; i++) begin
         idx = (int'(ptr_q) + i) % WIDTH;
         if (!found && req[idx]) begin
            found    = 1'b1;
            gnt[idx] = 1'b1;
            win_idx  = PTR_W'(idx);
         end
      end
   end

   // move priority to the requester after the winner
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         ptr_q <= '0;
      end else if (advance && |gnt) begin
         if (int'(win_idx) == WIDTH - 1) begin
            ptr_q <= '0;
         end else begin
            ptr_q <= win_idx + PTR_W'(1);
         end
      end
   end

   a_gnt_onehot: assert property (@(posedge clk) disable iff (!arst_n)
      $onehot0(gnt));

   a_gnt_in_req: assert property (@(posedge clk) disable iff (!arst_n)
      (gnt & ~req) == '0);

endmodule

/* hdl/im_alloc.sv */
// input-module allocator for one port; matches channels to cm links and turns grants into acks
module im_alloc
   import clos_pkg::*;
#(
   parameter int NUM_VC = 2,
   parameter int NUM_CM = 2
) (
   input  logic                             clk,
   input  logic                             arst_n,
   input  vc_req_t [NUM_VC-1:0]             vc_req,
   output vc_req_t [NUM_CM-1:0]             link_req,
   input  logic    [NUM_CM-1:0]             link_gnt,
   output logic    [NUM_VC-1:0]             ack,
   output logic    [NUM_CM-1:0][NUM_VC-1:0] cfg
);

   logic [NUM_VC-1:0]             req_vld;
   logic [NUM_VC-1:0]             held;
   logic [NUM_VC-1:0]             won;
   logic [NUM_CM-1:0][NUM_VC-1:0] avail;
   logic [NUM_CM-1:0][NUM_VC-1:0] sel;
   logic [NUM_CM-1:0][NUM_VC-1:0] match_q;

   always_comb begin
      for (int v = 0; v < NUM_VC; v++) begin
         req_vld[v] = vc_req[v].valid;
      end
   end

   // channels sitting in the match register are busy this cycle
   // won marks those whose link got through the central module
   always_comb begin
      held = '0;
      won  = '0;
      for (int k = 0; k < NUM_CM; k++) begin
         held = held | match_q[k];
         if (link_gnt[k]) begin
            won = won | match_q[k];
         end
      end
   end

   // stage 1 match, chained over the links within one cycle
   // link k only sees what the lower links left over
   generate
      for (genvar k = 0; k < NUM_CM; k++) begin : g_link
         if (k == 0) begin : g_first
            assign avail[k] = req_vld & ~held;
         end else begin : g_next
            assign avail[k] = avail[k-1] & ~sel[k-1];
         end

         rr_arbiter #(
            .WIDTH   (NUM_VC)
         ) u_link_arb (
            .clk     (clk),
            .arst_n  (arst_n),
            .req     (avail[k]),
            .advance (|avail[k]),
            .gnt     (sel[k])
         );
      end
   endgenerate

   // each link carries the live request of its matched channel
   // requester holds dst steady until ack, so no copy is kept
   always_comb begin
      link_req = '0;
      for (int k = 0; k < NUM_CM; k++) begin
         for (int v = 0; v < NUM_VC; v++) begin
            if (match_q[k][v]) begin
               link_req[k] = vc_req[v];
            end
         end
      end
   end

   // match is replaced on every edge so refused channels fall back to the pool
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         match_q <= '0;
         ack     <= '0;
         cfg     <= '0;
      end else begin
         match_q <= sel;
         ack     <= won;
         for (int k = 0; k < NUM_CM; k++) begin
            if (link_gnt[k]) begin
               cfg[k] <= match_q[k];
            end else begin
               cfg[k] <= '0;
            end
         end
      end
   end

   // ack must trace back to a matched channel with a valid request
   generate
      for (genvar v = 0; v < NUM_VC; v++) begin : g_chk_ack
         a_ack_matched: assert property (@(posedge clk) disable iff (!arst_n)
            ack[v] |-> $past(held[v] && req_vld[v]));
      end

      for (genvar k = 0; k < NUM_CM; k++) begin : g_chk_cfg
         a_cfg_onehot: assert property (@(posedge clk) disable iff (!arst_n)
            $onehot0(cfg[k]));
      end
   endgenerate

endmodule

/* hdl/cm_alloc.sv */
// central-module allocator; grants each output direction to one incoming link per slot
module cm_alloc
   import clos_pkg::*;
(
   input  logic                       clk,
   input  logic                       arst_n,
   input  vc_req_t     [NUM_DIRS-1:0] link_req,
   output logic        [NUM_DIRS-1:0] link_gnt,
   output cm_out_cfg_t [NUM_DIRS-1:0] cfg
);

   // first index is the output direction, second the incoming link
   logic [NUM_DIRS-1:0][NUM_DIRS-1:0] dir_req;
   logic [NUM_DIRS-1:0][NUM_DIRS-1:0] dir_gnt;
   cm_out_cfg_t [NUM_DIRS-1:0]        cfg_d;

   // sort valid link requests by destination
   always_comb begin
      for (int d = 0; d < NUM_DIRS; d++) begin
         for (int p = 0; p < NUM_DIRS; p++) begin
            dir_req[d][p] = link_req[p].valid && (link_req[p].dst == dir_t'(d));
         end
      end
   end

   // one arbiter per output whose pointer moves only after a grant
   generate
      for (genvar d = 0; d < NUM_DIRS; d++) begin : g_out
         rr_arbiter #(
            .WIDTH   (NUM_DIRS)
         ) u_out_arb (
            .clk     (clk),
            .arst_n  (arst_n),
            .req     (dir_req[d]),
            .advance (|dir_gnt[d]),
            .gnt     (dir_gnt[d])
         );
      end
   endgenerate

   // a link asks for a single output, so at most one term is set
   always_comb begin
      link_gnt = '0;
      for (int d = 0; d < NUM_DIRS; d++) begin
         link_gnt = link_gnt | dir_gnt[d];
      end
   end

   // winning source per output
   always_comb begin
      cfg_d = '0;
      for (int d = 0; d < NUM_DIRS; d++) begin
         cfg_d[d].valid = |dir_gnt[d];
         for (int p = 0; p < NUM_DIRS; p++) begin
            if (dir_gnt[d][p]) begin
               cfg_d[d].src = dir_t'(p);
            end
         end
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         cfg <= '0;
      end else begin
         cfg <= cfg_d;
      end
   end

   // the link side comes from the input modules
   generate
      for (genvar p = 0; p < NUM_DIRS; p++) begin : g_chk
         a_gnt_has_req: assert property (@(posedge clk) disable iff (!arst_n)
            link_gnt[p] |-> link_req[p].valid);

         // U-turns never reach a central module
         a_no_uturn: assert property (@(posedge clk) disable iff (!arst_n)
            link_req[p].valid |-> (link_req[p].dst != dir_t'(p)));
      end
   endgenerate

endmodule

/* hdl/clos_sched.sv */
// top level of the clos switch scheduler; five input-module allocators feeding NUM_CM central modules
module clos_sched
   import clos_pkg::*;
#(
   parameter int NUM_CM = 2,
   parameter int NUM_VC = 2
) (
   input  logic                                         clk,
   input  logic                                         arst_n,
   input  vc_req_t     [NUM_DIRS-1:0][NUM_VC-1:0]       req,
   output logic        [NUM_DIRS-1:0][NUM_VC-1:0]       ack,
   output logic        [NUM_DIRS-1:0][NUM_CM-1:0][NUM_VC-1:0] im_cfg,
   output cm_out_cfg_t [NUM_CM-1:0][NUM_DIRS-1:0]       cm_cfg
);

   // links as seen from the input side, indexed port then cm
   vc_req_t [NUM_DIRS-1:0][NUM_CM-1:0] im_link_req;
   logic    [NUM_DIRS-1:0][NUM_CM-1:0] im_link_gnt;

   // same links from the central side, indexed cm then port
   vc_req_t [NUM_CM-1:0][NUM_DIRS-1:0] cm_link_req;
   logic    [NUM_CM-1:0][NUM_DIRS-1:0] cm_link_gnt;

   // input modules, one per router port
   generate
      for (genvar p = 0; p < NUM_DIRS; p++) begin : g_im
         im_alloc #(
            .NUM_VC   (NUM_VC),
            .NUM_CM   (NUM_CM)
         ) u_im (
            .clk      (clk),
            .arst_n   (arst_n),
            .vc_req   (req[p]),
            .link_req (im_link_req[p]),
            .link_gnt (im_link_gnt[p]),
            .ack      (ack[p]),
            .cfg      (im_cfg[p])
         );
      end
   endgenerate

   // central modules, grants come back in the same cycle
   generate
      for (genvar k = 0; k < NUM_CM; k++) begin : g_cm
         cm_alloc u_cm (
            .clk      (clk),
            .arst_n   (arst_n),
            .link_req (cm_link_req[k]),
            .link_gnt (cm_link_gnt[k]),
            .cfg      (cm_cfg[k])
         );
      end
   endgenerate

   // transpose between the two link views
   // input port p lands on input p of every central module
   generate
      for (genvar p = 0; p < NUM_DIRS; p++) begin : g_link_p
         for (genvar k = 0; k < NUM_CM; k++) begin : g_link_k
            assign cm_link_req[k][p] = im_link_req[p][k];
            assign im_link_gnt[p][k] = cm_link_gnt[k][p];
         end
      end
   endgenerate

endmodule

/* verification/clos_sched_tb.sv */
// directed testbench for the clos switch scheduler; run with src.f and clos_sched_tb as top
module clos_sched_tb
   import clos_pkg::*;
();

   localparam int NUM_CM = 2;
   localparam int NUM_VC = 2;

   // longest wait from request to ack before it counts as starved
   localparam int MAX_LAT      = 64;
   localparam int RESET_CYCLES = 4;
   localparam int LONE_CYCLES  = NUM_DIRS * 3;
   localparam int HOT_CYCLES   = 64;
   localparam int FAIR_CYCLES  = 60;
   localparam int RAND_CYCLES  = 200;
   localparam int LIMIT_CYCLES = RESET_CYCLES + LONE_CYCLES + HOT_CYCLES
                                 + FAIR_CYCLES + RAND_CYCLES + 2 * MAX_LAT + 50;

   logic                                         clk;
   logic                                         arst_n;
   vc_req_t     [NUM_DIRS-1:0][NUM_VC-1:0]       req;
   logic        [NUM_DIRS-1:0][NUM_VC-1:0]       ack;
   logic        [NUM_DIRS-1:0][NUM_CM-1:0][NUM_VC-1:0] im_cfg;
   cm_out_cfg_t [NUM_CM-1:0][NUM_DIRS-1:0]       cm_cfg;

   // requests still waiting for their ack
   vc_req_t pend     [NUM_DIRS][NUM_VC];
   int      pend_age [NUM_DIRS][NUM_VC];
   int      ack_cnt  [NUM_DIRS];

   int          cycle_cnt = 0;
   int          err_cnt   = 0;
   logic [31:0] lcg_state = 32'd42715;

   clos_sched #(
      .NUM_CM (NUM_CM),
      .NUM_VC (NUM_VC)
   ) dut_i (
      .clk    (clk),
      .arst_n (arst_n),
      .req    (req),
      .ack    (ack),
      .im_cfg (im_cfg),
      .cm_cfg (cm_cfg)
   );

   initial clk = 1'b0;
   always #5 clk = ~clk;

   always @(posedge clk) begin
      cycle_cnt = cycle_cnt + 1;
      if (cycle_cnt > LIMIT_CYCLES) begin
         report_error($sformatf("timeout, run exceeded %0d cycles", LIMIT_CYCLES));
      end
   end

   task automatic stop_run();
      err_cnt = err_cnt + 1;
      $display("TESTBENCH FAILED");
      $fatal(1);
   endtask

   task automatic report_error(input string what);
      $display("%s", what);
      stop_run();
   endtask

   task automatic check_eq(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
      if (got !== exp) begin
         $display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
         stop_run();
      end
   endtask

   function automatic logic [31:0] rand_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state >> 8;
   endfunction

   function automatic int pending_count();
      int n;
      n = 0;
      for (int p = 0; p < NUM_DIRS; p++) begin
         for (int v = 0; v < NUM_VC; v++) begin
            if (pend[p][v].valid) begin
               n++;
            end
         end
      end
      return n;
   endfunction

   task automatic clear_model();
      for (int p = 0; p < NUM_DIRS; p++) begin
         ack_cnt[p] = 0;
         for (int v = 0; v < NUM_VC; v++) begin
            pend[p][v]     = '0;
            pend_age[p][v] = 0;
         end
      end
   endtask

   task automatic post_req(input int p, input int v, input int d);
      pend[p][v].valid = 1'b1;
      pend[p][v].dst   = dir_t'(d);
      pend_age[p][v]   = 0;
   endtask

   task automatic drive_req();
      for (int p = 0; p < NUM_DIRS; p++) begin
         for (int v = 0; v < NUM_VC; v++) begin
            req[p][v] = pend[p][v];
         end
      end
   endtask

   task automatic check_idle(input string when);
      for (int p = 0; p < NUM_DIRS; p++) begin
         check_eq($sformatf("ack[%0d] %s", p, when), ack[p], 0);
         check_eq($sformatf("im_cfg[%0d] %s", p, when), im_cfg[p], 0);
      end
      for (int k = 0; k < NUM_CM; k++) begin
         for (int d = 0; d < NUM_DIRS; d++) begin
            check_eq($sformatf("cm_cfg[%0d][%0d].valid %s", k, d, when),
                     cm_cfg[k][d].valid, 0);
         end
      end
   endtask

   // cross-check acks, im settings and cm settings of the slot just reported
   task automatic check_slot();
      int hits;
      int k_hit;
      int d;
      int s;
      int found;
      int port_gnts;
      int dir_acks [NUM_DIRS];
      for (int i = 0; i < NUM_DIRS; i++) begin
         dir_acks[i] = 0;
      end
      for (int p = 0; p < NUM_DIRS; p++) begin
         for (int v = 0; v < NUM_VC; v++) begin
            for (int k = 0; k < NUM_CM; k++) begin
               if (im_cfg[p][k][v] && !ack[p][v]) begin
                  report_error($sformatf("im_cfg marks port %0d channel %0d without an ack",
                                         p, v));
               end
            end
            if (ack[p][v]) begin
               if (!pend[p][v].valid) begin
                  report_error($sformatf("ack on port %0d channel %0d with no pending request",
                                         p, v));
               end
               d = int'(pend[p][v].dst);
               dir_acks[d]++;
               hits  = 0;
               k_hit = 0;
               for (int k = 0; k < NUM_CM; k++) begin
                  if (im_cfg[p][k][v]) begin
                     hits++;
                     k_hit = k;
                  end
               end
               check_eq($sformatf("im_cfg hits for ack[%0d][%0d]", p, v), hits, 1);
               check_eq($sformatf("cm_cfg[%0d][%0d].valid", k_hit, d),
                        cm_cfg[k_hit][d].valid, 1);
               check_eq($sformatf("cm_cfg[%0d][%0d].src", k_hit, d), cm_cfg[k_hit][d].src, p);
            end
         end
         // grants to this port as the central modules report them
         port_gnts = 0;
         for (int k = 0; k < NUM_CM; k++) begin
            for (int o = 0; o < NUM_DIRS; o++) begin
               if (cm_cfg[k][o].valid && int'(cm_cfg[k][o].src) == p) begin
                  port_gnts++;
               end
            end
         end
         if (port_gnts > NUM_CM) begin
            report_error($sformatf("port %0d got %0d grants in one slot", p, port_gnts));
         end
      end
      // also bounds the grants to a hot output
      for (int i = 0; i < NUM_DIRS; i++) begin
         if (dir_acks[i] > NUM_CM) begin
            report_error($sformatf("output %0d got %0d grants in one slot", i, dir_acks[i]));
         end
      end
      // every cm output setting needs one acked channel behind it
      for (int k = 0; k < NUM_CM; k++) begin
         for (int o = 0; o < NUM_DIRS; o++) begin
            if (cm_cfg[k][o].valid) begin
               s     = int'(cm_cfg[k][o].src);
               found = 0;
               for (int v = 0; v < NUM_VC; v++) begin
                  if (ack[s][v] && im_cfg[s][k][v] && int'(pend[s][v].dst) == o) begin
                     found++;
                  end
               end
               check_eq($sformatf("acked channels behind cm_cfg[%0d][%0d]", k, o), found, 1);
            end
         end
      end
   endtask

   // drive at the falling edge, then look at the slot one rising edge later
   task automatic tick();
      drive_req();
      @(posedge clk);
      @(negedge clk);
      check_slot();
      for (int p = 0; p < NUM_DIRS; p++) begin
         for (int v = 0; v < NUM_VC; v++) begin
            if (ack[p][v]) begin
               pend[p][v].valid = 1'b0;
               ack_cnt[p]++;
            end else if (pend[p][v].valid) begin
               pend_age[p][v]++;
               if (pend_age[p][v] > MAX_LAT) begin
                  report_error($sformatf("port %0d channel %0d not acked within %0d cycles",
                                         p, v, MAX_LAT));
               end
            end
         end
      end
   endtask

   task automatic wait_drained(input string what, input int budget);
      int spins;
      spins = 0;
      while (pending_count() > 0) begin
         if (spins >= budget) begin
            report_error($sformatf("%s left requests unserved after %0d cycles", what, budget));
         end
         tick();
         spins++;
      end
   endtask

   task automatic reset_checks();
      repeat (2) begin
         @(negedge clk);
         check_idle("during reset");
      end
      arst_n = 1'b1;
      tick();
      check_idle("after reset");
   endtask

   task automatic lone_request();
      int v;
      int d;
      int k_hit;
      for (int p = 0; p < NUM_DIRS; p++) begin
         v = p % NUM_VC;
         d = (p + 2) % NUM_DIRS;
         post_req(p, v, d);
         tick();
         check_eq($sformatf("ack[%0d][%0d] after one edge", p, v), ack[p][v], 0);
         tick();
         check_eq($sformatf("ack[%0d][%0d] after two edges", p, v), ack[p][v], 1);
         k_hit = -1;
         for (int k = 0; k < NUM_CM; k++) begin
            if (im_cfg[p][k][v]) begin
               k_hit = k;
            end
         end
         if (k_hit < 0) begin
            report_error($sformatf("lone request on port %0d has no im_cfg entry", p));
         end
         check_eq($sformatf("cm_cfg[%0d][%0d].valid", k_hit, d), cm_cfg[k_hit][d].valid, 1);
         check_eq($sformatf("cm_cfg[%0d][%0d].src", k_hit, d), cm_cfg[k_hit][d].src, p);
         tick();
      end
   endtask

   // all channels of south, west, north and east head for local
   task automatic hot_output();
      for (int p = 0; p < NUM_DIRS - 1; p++) begin
         for (int v = 0; v < NUM_VC; v++) begin
            post_req(p, v, int'(DIR_L));
         end
      end
      wait_drained("hot output", HOT_CYCLES);
   endtask

   task automatic fairness();
      int diff;
      for (int p = 0; p < NUM_DIRS; p++) begin
         ack_cnt[p] = 0;
      end
      for (int c = 0; c < FAIR_CYCLES; c++) begin
         if (!pend[DIR_W][0].valid) begin
            post_req(int'(DIR_W), 0, int'(DIR_N));
         end
         if (!pend[DIR_E][0].valid) begin
            post_req(int'(DIR_E), 0, int'(DIR_N));
         end
         tick();
      end
      diff = ack_cnt[DIR_W] - ack_cnt[DIR_E];
      if (diff < 0) begin
         diff = -diff;
      end
      if (diff > NUM_CM || ack_cnt[DIR_W] == 0) begin
         report_error($sformatf("unfair service, west got %0d acks and east %0d",
                                ack_cnt[DIR_W], ack_cnt[DIR_E]));
      end
      wait_drained("fairness", MAX_LAT);
   endtask

   task automatic random_traffic();
      logic [31:0] r;
      int          d;
      for (int c = 0; c < RAND_CYCLES; c++) begin
         for (int p = 0; p < NUM_DIRS; p++) begin
            for (int v = 0; v < NUM_VC; v++) begin
               r = rand_next();
               if (!pend[p][v].valid && r[0]) begin
                  // offset 1 to 4 keeps the destination off the own port
                  d = (p + 1 + int'(r[9:4] % 4)) % NUM_DIRS;
                  post_req(p, v, d);
               end
            end
         end
         tick();
      end
      wait_drained("random traffic", MAX_LAT);
   endtask

   initial begin
      arst_n = 1'b0;
      req    = '0;
      clear_model();
      reset_checks();
      lone_request();
      hot_output();
      fairness();
      random_traffic();
      if (err_cnt == 0) begin
         $display("TESTBENCH PASSED");
         $finish;
      end else begin
         report_error("errors were recorded during the run");
      end
   end

endmodule

/* src.f */
hdl/clos_pkg.sv
hdl/rr_arbiter.sv
hdl/im_alloc.sv
hdl/cm_alloc.sv
hdl/clos_sched.sv
verification/clos_sched_tb.sv

/* Bender.yml */
package:
  name: clos_sched

sources:
  # package first, then the arbiter, the allocators and the top level
  - files:
      - hdl/clos_pkg.sv
      - hdl/rr_arbiter.sv
      - hdl/im_alloc.sv
      - hdl/cm_alloc.sv
      - hdl/clos_sched.sv

  - target: test
    files:
      - verification/clos_sched_tb.sv
